//--- verilog.f
source/mem_pkg.sv
source/fetch_pkg.sv
source/imem.sv
source/mem_arbiter.sv
source/fetch_ctrl.sv
source/iprefetch.sv
source/fetch_top.sv
sim/tb_fetch.sv

//--- Makefile
TOP = tb_fetch

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f verilog.f --top-module fetch_top
	verilator --lint-only --timing -f verilog.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -Wno-fatal -f verilog.f --top-module $(TOP)
	./obj_dir/V$(TOP) > sim.log 2>&1; status=$$?; cat sim.log; \
	if [ $$status -ne 0 ] || grep -q "ERRORS FOUND" sim.log; then exit 1; fi

clean:
	rm -rf obj_dir sim.log

//--- sim/tb_fetch.sv
`timescale 1ns/1ns
`default_nettype none

module tb_fetch;

    localparam int          MEM_WORDS   = 256;
    localparam logic [31:0] BOOT_ADDR   = 32'h0000_0000;
    localparam int          PROG_BYTES  = 512;
    localparam int          WAIT_LIMIT  = 32;
    localparam logic [31:0] JUMP_TARGET = 32'h0000_0100;

    logic                  clk;
    logic                  reset_n;
    logic                  run;
    logic                  jump;
    logic [31:0]           jump_target;
    mem_pkg::host_req_t    host_req;
    mem_pkg::host_rsp_t    host_rsp;
    fetch_pkg::instr_out_t instr;

    // byte copy of the program, the model reads it
    logic [7:0]  ref_mem [MEM_WORDS*4];
    logic [31:0] lfsr;
    logic [31:0] exp_pc;
    int          errors;
    int          checks;
    int          tests;
    int          straddles;
    int          buffered_seen;

    // last word the model has consumed on this path
    logic [31:0] held_word;
    logic        held_ok;

    fetch_top #(
        .MEM_WORDS(MEM_WORDS),
        .BOOT_ADDR(BOOT_ADDR)
    ) dut_i (
        .clk          (clk),
        .reset_n      (reset_n),
        .run_i        (run),
        .jump_i       (jump),
        .jump_target_i(jump_target),
        .host_req_i   (host_req),
        .host_rsp_o   (host_rsp),
        .instr_o      (instr)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #10 clk = ~clk;
        end
    end

    // galois lfsr, one step per bit
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'hA300_0000) : (lfsr >> 1);
        end
        return v;
    endfunction

    // 32 bits of memory starting at a byte address
    function automatic logic [31:0] model_word(input logic [31:0] pc);
        return {ref_mem[pc+3], ref_mem[pc+2], ref_mem[pc+1], ref_mem[pc]};
    endfunction

    // compare against the model, then step the model pc
    task automatic check_instr(input fetch_pkg::instr_out_t got);
        logic [31:0] exp_instr;
        logic        exp_c;
        logic [31:0] need_word;
        logic        exp_p;
        exp_instr = model_word(exp_pc);
        exp_c     = (exp_instr[1:0] != 2'b11);
        // word that completes the instruction at this pc
        need_word = exp_pc[1] ? exp_pc + 32'd2 : exp_pc;
        // already brought in for the previous instruction
        exp_p     = held_ok && (need_word == held_word);
        checks++;
        if (got.pc !== exp_pc) begin
            $display("ERROR instr_o.pc got %h expected %h", got.pc, exp_pc);
            errors++;
        end
        if (got.instr !== exp_instr) begin
            $display("ERROR instr_o.instr got %h expected %h", got.instr, exp_instr);
            errors++;
        end
        if (got.compressed !== exp_c) begin
            $display("ERROR instr_o.compressed got %h expected %h", got.compressed, exp_c);
            errors++;
        end
        if (got.prefetched !== exp_p) begin
            $display("ERROR instr_o.prefetched got %h expected %h", got.prefetched, exp_p);
            errors++;
        end
        // coverage of the two joining cases
        if (exp_pc[1] && !exp_c) straddles++;
        if (exp_p) buffered_seen++;
        held_word = need_word;
        held_ok   = 1'b1;
        exp_pc    = exp_pc + (exp_c ? 32'd2 : 32'd4);
    endtask

    task automatic check_host_rsp(input mem_pkg::host_rsp_t got, input logic [31:0] exp_data);
        checks++;
        if (got.valid !== 1'b1) begin
            $display("host read gave no response one cycle after the request");
            errors++;
        end else if (got.data !== exp_data) begin
            $display("ERROR host_rsp_o.data got %h expected %h", got.data, exp_data);
            errors++;
        end
    endtask

    task automatic apply_reset();
        @(negedge clk);
        reset_n  = 1'b0;
        run      = 1'b0;
        jump     = 1'b0;
        host_req = '0;
        repeat (3) @(negedge clk);
        reset_n = 1'b1;
    endtask

    // random halfwords, 32-bit ones get low bits 11
    task automatic build_program(input logic all_full);
        int          pos;
        logic [31:0] rnd;
        logic [15:0] half;
        logic        full;
        pos = 0;
        while (pos < PROG_BYTES) begin
            rnd  = take_bits(1);
            full = all_full | rnd[0];
            rnd  = take_bits(16);
            half = rnd[15:0];
            if (full) begin
                half[1:0] = 2'b11;
            end else if (half[1:0] == 2'b11) begin
                half[1:0] = 2'b01;
            end
            ref_mem[pos]   = half[7:0];
            ref_mem[pos+1] = half[15:8];
            pos += 2;
            if (full) begin
                rnd            = take_bits(16);
                ref_mem[pos]   = rnd[7:0];
                ref_mem[pos+1] = rnd[15:8];
                pos += 2;
            end
        end
    endtask

    // one host write per cycle
    task automatic load_program();
        for (int w = 0; w < PROG_BYTES / 4; w++) begin
            @(negedge clk);
            host_req.valid = 1'b1;
            host_req.op    = mem_pkg::HOST_WRITE;
            host_req.addr  = w * 4;
            host_req.wdata = model_word(w * 4);
        end
        @(negedge clk);
        host_req = '0;
    endtask

    // sample after the inputs of the cycle settle
    task automatic collect(input int count);
        int got_n;
        int waited;
        got_n  = 0;
        waited = 0;
        while (got_n < count && waited < WAIT_LIMIT) begin
            @(negedge clk);
            #2;
            if (instr.valid) begin
                check_instr(instr);
                got_n++;
                waited = 0;
            end else begin
                waited++;
            end
        end
        if (got_n < count) begin
            $display("timeout: no instruction for %0d cycles, got %0d of %0d",
                     WAIT_LIMIT, got_n, count);
            errors++;
        end
    endtask

    task automatic start_fetch();
        @(negedge clk);
        run     = 1'b1;
        exp_pc  = BOOT_ADDR;
        held_ok = 1'b0;
    endtask

    task automatic test_reset_state();
        apply_reset();
        repeat (10) begin
            @(negedge clk);
            #2;
            checks++;
            if (instr.valid !== 1'b0 || host_rsp.valid !== 1'b0) begin
                $display("a valid strobe went high while idle after reset");
                errors++;
            end
        end
    endtask

    // scratch words well above the program
    task automatic test_host_port();
        logic [31:0] data [8];
        for (int i = 0; i < 8; i++) begin
            data[i] = take_bits(32);
            @(negedge clk);
            host_req.valid = 1'b1;
            host_req.op    = mem_pkg::HOST_WRITE;
            host_req.addr  = 32'd800 + i * 4;
            host_req.wdata = data[i];
        end
        for (int i = 0; i < 8; i++) begin
            @(negedge clk);
            host_req.valid = 1'b1;
            host_req.op    = mem_pkg::HOST_READ;
            host_req.addr  = 32'd800 + i * 4;
            @(negedge clk);
            host_req = '0;
            #2;
            check_host_rsp(host_rsp, data[i]);
        end
    endtask

    task automatic test_full_words();
        apply_reset();
        build_program(1'b1);
        load_program();
        start_fetch();
        collect(16);
    endtask

    task automatic test_mixed();
        apply_reset();
        build_program(1'b0);
        load_program();
        straddles     = 0;
        buffered_seen = 0;
        start_fetch();
        collect(40);
        if (straddles == 0 || buffered_seen == 0) begin
            $display("mixed program never straddled a word or never used the buffer");
            errors++;
        end
    endtask

    task automatic test_jump();
        apply_reset();
        start_fetch();
        collect(10);
        // skip the request cycle, jump while a word is returning
        @(negedge clk);
        @(negedge clk);
        jump        = 1'b1;
        jump_target = JUMP_TARGET;
        exp_pc      = JUMP_TARGET;
        held_ok     = 1'b0;
        #2;
        if (instr.valid) begin
            $display("old path instruction issued in the jump cycle");
            errors++;
        end
        @(negedge clk);
        jump = 1'b0;
        #2;
        if (instr.valid) check_instr(instr);
        collect(12);
    endtask

    // reads of the program every cycle, fetch must stall
    task automatic test_host_priority();
        apply_reset();
        start_fetch();
        collect(8);
        for (int i = 0; i < 12; i++) begin
            @(negedge clk);
            host_req.valid = 1'b1;
            host_req.op    = mem_pkg::HOST_READ;
            host_req.addr  = i * 4;
            #2;
            if (i > 0) check_host_rsp(host_rsp, model_word((i - 1) * 4));
            if (instr.valid) begin
                if (i > 0) begin
                    $display("instruction issued while the host held the memory");
                    errors++;
                end
                check_instr(instr);
            end
        end
        @(negedge clk);
        host_req = '0;
        #2;
        check_host_rsp(host_rsp, model_word(32'd44));
        if (instr.valid) check_instr(instr);
        collect(16);
    endtask

    task automatic finish_test(input string name, input int mark);
        tests++;
        if (errors == mark) begin
            $display("test %s passed", name);
        end else begin
            $display("test %s failed with %0d errors", name, errors - mark);
        end
    endtask

    initial begin
        int mark;
        lfsr        = 32'h43b0_d5f0;
        errors      = 0;
        checks      = 0;
        tests       = 0;
        reset_n     = 1'b0;
        run         = 1'b0;
        jump        = 1'b0;
        jump_target = '0;
        host_req    = '0;
        exp_pc      = '0;
        mark = errors;
        test_reset_state();
        finish_test("reset_state", mark);
        mark = errors;
        test_host_port();
        finish_test("host_port", mark);
        mark = errors;
        test_full_words();
        finish_test("full_words", mark);
        mark = errors;
        test_mixed();
        finish_test("mixed", mark);
        mark = errors;
        test_jump();
        finish_test("jump", mark);
        mark = errors;
        test_host_priority();
        finish_test("host_priority", mark);
        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- source/fetch_top.sv
`timescale 1ns/1ns
`default_nettype none

module fetch_top #(
    parameter int          MEM_WORDS = 256,
    parameter logic [31:0] BOOT_ADDR = 32'h0000_0000
) (
    input  logic                  clk,
    input  logic                  reset_n,
    input  logic                  run_i,
    input  logic                  jump_i,
    input  logic [31:0]           jump_target_i,
    input  mem_pkg::host_req_t    host_req_i,
    output mem_pkg::host_rsp_t    host_rsp_o,
    output fetch_pkg::instr_out_t instr_o
);

    // fetch side of the memory port
    logic                   fetch_req;
    logic [31:0]            fetch_addr;
    logic                   fetch_gnt;
    logic                   fetch_rsp_valid;
    logic [31:0]            fetch_rdata;

    // word stream into the prefetcher
    fetch_pkg::fetch_word_t fetch_word;

    // host has priority, fetch waits
    mem_arbiter #(
        .MEM_WORDS(MEM_WORDS)
    ) mem_arbiter_i (
        .clk              (clk),
        .reset_n          (reset_n),
        .host_req_i       (host_req_i),
        .host_rsp_o       (host_rsp_o),
        .fetch_req_i      (fetch_req),
        .fetch_addr_i     (fetch_addr),
        .fetch_gnt_o      (fetch_gnt),
        .fetch_rsp_valid_o(fetch_rsp_valid),
        .fetch_rdata_o    (fetch_rdata)
    );

    // next address depends on the prefetcher's answer
    fetch_ctrl #(
        .BOOT_ADDR(BOOT_ADDR)
    ) fetch_ctrl_i (
        .clk              (clk),
        .reset_n          (reset_n),
        .run_i            (run_i),
        .jump_i           (jump_i),
        .jump_target_i    (jump_target_i),
        .fetch_req_o      (fetch_req),
        .fetch_addr_o     (fetch_addr),
        .fetch_gnt_i      (fetch_gnt),
        .fetch_rsp_valid_i(fetch_rsp_valid),
        .fetch_rdata_i    (fetch_rdata),
        .prefetched_i     (instr_o.prefetched),
        .fetch_word_o     (fetch_word)
    );

    // zero latency word to instruction
    iprefetch iprefetch_i (
        .clk         (clk),
        .reset_n     (reset_n),
        .fetch_word_i(fetch_word),
        .instr_o     (instr_o)
    );

endmodule

`default_nettype wire

//--- source/iprefetch.sv
`timescale 1ns/1ns
`default_nettype none

module iprefetch (
    input  logic                   clk,
    input  logic                   reset_n,
    input  fetch_pkg::fetch_word_t fetch_word_i,
    output fetch_pkg::instr_out_t  instr_o
);

    logic            enable;
    fetch_pkg::tag_t tag_r;
    logic            tag_match;

    logic [31:0]     pc;
    logic [31:0]     pc_r;
    logic [31:0]     pc_step;

    logic            compressed;
    logic            misaligned;
    logic            misaligned_r;
    logic            buffered;

    logic [31:0]     word_r;
    logic [31:0]     instr;

    assign enable = fetch_word_i.valid;

    // tag check
    // a new tag means a redirect, so the word address is the pc
    assign tag_match = (fetch_word_i.tag == tag_r);
    assign pc        = tag_match ? pc_r : fetch_word_i.addr;

    // pc on a halfword boundary
    // instruction starts in the upper half of the previous word
    assign misaligned = pc[1];

    // last step left pc at the start of the stored word
    // stale after a redirect
    assign buffered = tag_match && misaligned_r && !misaligned;

    // pick the 32 bits at pc
    always_comb begin
        if (misaligned) begin
            // upper half of old word, lower half of new one
            instr = {fetch_word_i.data[15:0], word_r[31:16]};
        end else if (buffered) begin
            instr = word_r;
        end else begin
            instr = fetch_word_i.data;
        end
    end

    // RVC when the low two bits are not 11
    assign compressed = (instr[1:0] != 2'b11);
    assign pc_step    = compressed ? 32'd2 : 32'd4;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            tag_r        <= '0;
            pc_r         <= '0;
            misaligned_r <= 1'b0;
        end else if (enable) begin
            tag_r        <= fetch_word_i.tag;
            pc_r         <= pc + pc_step;
            misaligned_r <= misaligned;
        end
    end

    // keep the stored word while issuing it
    // the refetched word must join with it next time
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            word_r <= '0;
        end else if (enable && !buffered) begin
            word_r <= fetch_word_i.data;
        end
    end

    assign instr_o.valid      = enable;
    assign instr_o.compressed = compressed;
    assign instr_o.prefetched = enable && buffered;
    assign instr_o.pc         = pc;
    assign instr_o.instr      = instr;

    // steps of 2 and 4 from word aligned targets keep pc even
    a_pc_even: assert property (@(posedge clk) disable iff (!reset_n)
        instr_o.valid |-> !instr_o.pc[0]);

endmodule

`default_nettype wire

//--- source/fetch_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module fetch_ctrl #(
    parameter logic [31:0] BOOT_ADDR = 32'h0000_0000
) (
    input  logic                   clk,
    input  logic                   reset_n,
    input  logic                   run_i,
    input  logic                   jump_i,
    input  logic [31:0]            jump_target_i,
    output logic                   fetch_req_o,
    output logic [31:0]            fetch_addr_o,
    input  logic                   fetch_gnt_i,
    input  logic                   fetch_rsp_valid_i,
    input  logic [31:0]            fetch_rdata_i,
    input  logic                   prefetched_i,
    output fetch_pkg::fetch_word_t fetch_word_o
);

    fetch_pkg::fetch_state_e state_r;
    logic [31:0]             addr_r;
    fetch_pkg::tag_t         tag_r;
    logic                    rsp_live;

    // request held until granted
    assign fetch_req_o  = (state_r == fetch_pkg::REQUEST);
    assign fetch_addr_o = addr_r;

    // only the response awaited in WAIT is forwarded
    // one arriving after a jump belongs to the old path
    assign rsp_live = fetch_rsp_valid_i && (state_r == fetch_pkg::WAIT) && !jump_i;

    // word goes out in the cycle its data returns
    assign fetch_word_o.valid = rsp_live;
    assign fetch_word_o.tag   = tag_r;
    assign fetch_word_o.addr  = addr_r;
    assign fetch_word_o.data  = fetch_rdata_i;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state_r <= fetch_pkg::IDLE;
            addr_r  <= '0;
            tag_r   <= '0;
        end else if (jump_i) begin
            // redirect
            // new tag makes the prefetcher drop its pc
            addr_r  <= jump_target_i;
            tag_r   <= tag_r + 1'b1;
            state_r <= run_i ? fetch_pkg::REQUEST : fetch_pkg::IDLE;
        end else begin
            case (state_r)
                fetch_pkg::IDLE: begin
                    // start from boot, counts as a redirect
                    if (run_i) begin
                        addr_r  <= BOOT_ADDR;
                        tag_r   <= tag_r + 1'b1;
                        state_r <= fetch_pkg::REQUEST;
                    end
                end
                fetch_pkg::REQUEST: begin
                    if (!run_i) begin
                        state_r <= fetch_pkg::IDLE;
                    end else if (fetch_gnt_i) begin
                        state_r <= fetch_pkg::WAIT;
                    end
                end
                fetch_pkg::WAIT: begin
                    // grant is registered, so data comes next cycle
                    if (fetch_rsp_valid_i) begin
                        // buffered word issued, this word still unused
                        if (!prefetched_i) begin
                            addr_r <= addr_r + 32'd4;
                        end
                        state_r <= run_i ? fetch_pkg::REQUEST : fetch_pkg::IDLE;
                    end
                end
                default: begin
                    state_r <= fetch_pkg::IDLE;
                end
            endcase
        end
    end

    // word fetch only, targets never land mid word
    a_target_aligned: assert property (@(posedge clk) disable iff (!reset_n)
        jump_i |-> (jump_target_i[1:0] == 2'b00));

endmodule

`default_nettype wire

//--- source/mem_arbiter.sv
`timescale 1ns/1ns
`default_nettype none

module mem_arbiter #(
    parameter int MEM_WORDS = 256
) (
    input  logic               clk,
    input  logic               reset_n,
    input  mem_pkg::host_req_t host_req_i,
    output mem_pkg::host_rsp_t host_rsp_o,
    input  logic               fetch_req_i,
    input  logic [31:0]        fetch_addr_i,
    output logic               fetch_gnt_o,
    output logic               fetch_rsp_valid_o,
    output logic [31:0]        fetch_rdata_o
);

    localparam int AW = $clog2(MEM_WORDS);

    mem_pkg::grant_e grant;
    mem_pkg::grant_e owner_next;
    mem_pkg::grant_e owner_r;

    logic        mem_en;
    logic        mem_we;
    logic [31:0] mem_byte_addr;
    logic [31:0] mem_wdata;
    logic [31:0] mem_rdata;

    // fixed priority
    // host always wins, fetch only on a free port
    always_comb begin
        if (host_req_i.valid) begin
            grant = mem_pkg::GRANT_HOST;
        end else if (fetch_req_i) begin
            grant = mem_pkg::GRANT_FETCH;
        end else begin
            grant = mem_pkg::GRANT_NONE;
        end
    end

    assign fetch_gnt_o = (grant == mem_pkg::GRANT_FETCH);

    // steer the winner onto the memory port
    always_comb begin
        mem_en        = 1'b0;
        mem_we        = 1'b0;
        mem_byte_addr = fetch_addr_i;
        mem_wdata     = host_req_i.wdata;
        case (grant)
            mem_pkg::GRANT_HOST: begin
                mem_en        = 1'b1;
                mem_we        = (host_req_i.op == mem_pkg::HOST_WRITE);
                mem_byte_addr = host_req_i.addr;
            end
            mem_pkg::GRANT_FETCH: begin
                mem_en = 1'b1;
            end
            default: begin
                mem_en = 1'b0;
            end
        endcase
    end

    // host writes return nothing
    assign owner_next = (grant == mem_pkg::GRANT_HOST && mem_we) ? mem_pkg::GRANT_NONE : grant;

    // remember who gets next cycle's read data
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            owner_r <= mem_pkg::GRANT_NONE;
        end else begin
            owner_r <= owner_next;
        end
    end

    imem #(
        .MEM_WORDS(MEM_WORDS)
    ) imem_i (
        .clk    (clk),
        .en_i   (mem_en),
        .we_i   (mem_we),
        .addr_i (mem_byte_addr[AW+1:2]),
        .wdata_i(mem_wdata),
        .rdata_o(mem_rdata)
    );

    // read data to its owner
    assign host_rsp_o.valid  = (owner_r == mem_pkg::GRANT_HOST);
    assign host_rsp_o.data   = mem_rdata;
    assign fetch_rsp_valid_o = (owner_r == mem_pkg::GRANT_FETCH);
    assign fetch_rdata_o     = mem_rdata;

    // address check on anything reaching the array
    a_addr_ok: assert property (@(posedge clk) disable iff (!reset_n)
        mem_en |-> (mem_byte_addr[1:0] == 2'b00 && mem_byte_addr[31:2] < MEM_WORDS));

endmodule

`default_nettype wire

//--- source/imem.sv
`timescale 1ns/1ns
`default_nettype none

module imem #(
    parameter int MEM_WORDS = 256
) (
    input  logic                         clk,
    input  logic                         en_i,
    input  logic                         we_i,
    input  logic [$clog2(MEM_WORDS)-1:0] addr_i,
    input  logic [31:0]                  wdata_i,
    output logic [31:0]                  rdata_o
);

    // word array
    logic [31:0] mem [MEM_WORDS];

    // single port
    // write in place, read registered
    always_ff @(posedge clk) begin
        if (en_i) begin
            if (we_i) begin
                mem[addr_i] <= wdata_i;
            end else begin
                // data shows up the cycle after the access
                rdata_o <= mem[addr_i];
            end
        end
    end

endmodule

`default_nettype wire

//--- source/fetch_pkg.sv
`default_nettype none

package fetch_pkg;

    // redirect tag, bumped on every jump and on run start
    typedef logic [2:0] tag_t;

    // one fetched word
    // addr is the word address the data came from
    typedef struct packed {
        logic        valid;
        tag_t        tag;
        logic [31:0] addr;
        logic [31:0] data;
    } fetch_word_t;

    // one instruction leaving the prefetcher
    // prefetched set when the buffered word was issued
    typedef struct packed {
        logic        valid;
        logic        compressed;
        logic        prefetched;
        logic [31:0] pc;
        logic [31:0] instr;
    } instr_out_t;

    // fetch controller states
    typedef enum logic [1:0] {
        IDLE    = 2'd0,
        REQUEST = 2'd1,
        WAIT    = 2'd2
    } fetch_state_e;

endpackage

`default_nettype wire

//--- source/mem_pkg.sv
`default_nettype none

package mem_pkg;

    // kind of host access
    typedef enum logic {
        HOST_READ  = 1'b0,
        HOST_WRITE = 1'b1
    } host_op_e;

    // one host access
    // byte address, word data
    typedef struct packed {
        logic        valid;
        host_op_e    op;
        logic [31:0] addr;
        logic [31:0] wdata;
    } host_req_t;

    // read result, one cycle after the request
    typedef struct packed {
        logic        valid;
        logic [31:0] data;
    } host_rsp_t;

    // current owner of the memory port
    // also used for the registered read data owner
    typedef enum logic [1:0] {
        GRANT_NONE  = 2'd0,
        GRANT_HOST  = 2'd1,
        GRANT_FETCH = 2'd2
    } grant_e;

endpackage

`default_nettype wire
